// File: common/mipsIsaPkg.sv
`default_nettype none

package mipsIsaPkg;

    localparam int WordW    = 32;
    localparam int RegAddrW = 5;
    localparam int NumRegs  = 32;
    localparam int ImmW     = 16;            // I-type immediate width
    localparam int PcStep   = 4;             // Bytes per instruction

    typedef logic [WordW-1:0]    wordT;
    typedef logic [RegAddrW-1:0] regAddrT;

    // Low 16 bits double as the I-type immediate
    typedef struct packed {
        logic [5:0] op;
        regAddrT    rs;
        regAddrT    rt;
        regAddrT    rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instrT;

    // Opcodes
    localparam logic [5:0] OpRType = 6'b000000;
    localparam logic [5:0] OpLw    = 6'b100011;
    localparam logic [5:0] OpSw    = 6'b101011;
    localparam logic [5:0] OpBeq   = 6'b000100;

    // R-type funct codes
    localparam logic [5:0] FnAdd = 6'b100000;
    localparam logic [5:0] FnSub = 6'b100010;
    localparam logic [5:0] FnAnd = 6'b100100;
    localparam logic [5:0] FnOr  = 6'b100101;
    localparam logic [5:0] FnSlt = 6'b101010;

endpackage

`default_nettype wire

// File: common/mipsCtrlPkg.sv
`default_nettype none

package mipsCtrlPkg;

    import mipsIsaPkg::*;

    // Main decoder to ALU decoder
    typedef enum logic [1:0] {
        AluOpAdd   = 2'b00,
        AluOpSub   = 2'b01,
        AluOpFunct = 2'b10
    } aluOpT;

    typedef enum logic [3:0] {
        AluAnd = 4'b0000,
        AluOr  = 4'b0001,
        AluAdd = 4'b0010,
        AluSub = 4'b0110,
        AluSlt = 4'b0111
    } aluCtlT;

    typedef struct packed {
        logic  regDst;                      // rd instead of rt
        logic  branch;
        logic  memRead;
        logic  memToReg;                    // Load data to register file
        aluOpT aluOp;
        logic  memWrite;
        logic  aluSrc;                      // Immediate as operand b
        logic  regWrite;
    } ctrlT;

    localparam ctrlT CtrlNone = '0;         // No side effects

    typedef struct packed {
        logic    en;
        regAddrT addr;
        wordT    data;
    } retireT;

endpackage

`default_nettype wire

// File: src/ControlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module ControlUnit
    import mipsIsaPkg::*;
    import mipsCtrlPkg::*;
(
    input  wire [5:0] op,                   // Opcode field
    output ctrlT      ctrl
);

    always_comb begin
        ctrl = CtrlNone;                    // Unknown opcodes do nothing
        case (op)
            OpRType: begin
                ctrl.regDst   = 1'b1;
                ctrl.aluSrc   = 1'b0;
                ctrl.memToReg = 1'b0;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = AluOpFunct;
            end
            OpLw: begin
                ctrl.regDst   = 1'b0;
                ctrl.aluSrc   = 1'b1;        // Base plus offset
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.aluOp    = AluOpAdd;
            end
            OpSw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.aluOp    = AluOpAdd;
            end
            OpBeq: begin
                ctrl.aluSrc   = 1'b0;        // Compare rs against rt
                ctrl.branch   = 1'b1;
                ctrl.aluOp    = AluOpSub;
            end
            default: begin
                ctrl = CtrlNone;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: alu/AluControl.sv
`timescale 1ns/1ps
`default_nettype none

module AluControl
    import mipsIsaPkg::*;
    import mipsCtrlPkg::*;
(
    input  wire aluOpT aluOp,
    input  wire [5:0]  funct,
    output aluCtlT     aluCtl
);

    always_comb begin
        case (aluOp)
            AluOpAdd: aluCtl = AluAdd;       // Address calculation
            AluOpSub: aluCtl = AluSub;       // Branch compare
            AluOpFunct: begin
                case (funct)
                    FnAdd:   aluCtl = AluAdd;
                    FnSub:   aluCtl = AluSub;
                    FnAnd:   aluCtl = AluAnd;
                    FnOr:    aluCtl = AluOr;
                    FnSlt:   aluCtl = AluSlt;
                    default: aluCtl = AluAdd; // Unsupported funct
                endcase
            end
            default: aluCtl = AluAdd;
        endcase
    end

endmodule

`default_nettype wire

// File: alu/Alu.sv
`timescale 1ns/1ps
`default_nettype none

module Alu
    import mipsIsaPkg::*;
    import mipsCtrlPkg::*;
(
    input  wire wordT   a,
    input  wire wordT   b,
    input  wire aluCtlT aluCtl,
    output wordT        result,
    output logic        zero
);

    always_comb begin
        case (aluCtl)
            AluAnd: result = a & b;
            AluOr:  result = a | b;
            AluAdd: result = a + b;
            AluSub: result = a - b;
            AluSlt: begin
                // Signed compare gives 0 or 1
                if ($signed(a) < $signed(b)) begin
                    result = wordT'(1);
                end else begin
                    result = '0;
                end
            end
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);            // Drives beq

endmodule

`default_nettype wire

// File: src/RegFile.sv
`timescale 1ns/1ps
`default_nettype none

module RegFile
    import mipsIsaPkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire regAddrT rAddrA,
    input  wire regAddrT rAddrB,
    output wordT         rDataA,
    output wordT         rDataB,
    input  wire          we,
    input  wire regAddrT wAddr,
    input  wire wordT    wData
);

    wordT regs [NumRegs];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wAddr != '0)) begin
            regs[wAddr] <= wData;           // $zero is never written
        end
    end

    // Same-cycle read sees the old value
    assign rDataA = (rAddrA == '0) ? '0 : regs[rAddrA];
    assign rDataB = (rAddrB == '0) ? '0 : regs[rAddrB];

endmodule

`default_nettype wire

// File: src/MipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module MipsCore
    import mipsIsaPkg::*;
    import mipsCtrlPkg::*;
(
    input  wire        clk,
    input  wire        rst,
    output wordT       iAddr,
    input  wire instrT instr,
    output wordT       dAddr,
    output wordT       dWdata,
    output logic       dWe,
    output logic       dRe,
    input  wire wordT  dRdata,
    output retireT     retire
);

    wordT    pc;
    wordT    pcPlus4;
    wordT    branchTarget;
    wordT    nextPc;
    logic    running;                       // Low for one bubble cycle after reset
    ctrlT    ctrl;
    aluCtlT  aluCtl;
    wordT    signExtImm;
    wordT    rDataA;
    wordT    rDataB;
    wordT    aluB;
    wordT    aluResult;
    logic    zero;
    regAddrT writeReg;
    wordT    wbData;
    logic    regWe;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= '0;
            running <= 1'b0;
        end else begin
            running <= 1'b1;
            if (running) begin
                pc <= nextPc;
            end
        end
    end

    assign iAddr = pc;

    // Next PC
    assign signExtImm   = {{(WordW-ImmW){instr[ImmW-1]}}, instr[ImmW-1:0]};
    assign pcPlus4      = pc + wordT'(PcStep);
    assign branchTarget = pcPlus4 + (signExtImm << 2);
    assign nextPc       = (ctrl.branch && zero) ? branchTarget : pcPlus4;

    ControlUnit ControlUnit_inst (
        .op   (instr.op),
        .ctrl (ctrl)
    );

    AluControl AluControl_inst (
        .aluOp  (ctrl.aluOp),
        .funct  (instr.funct),
        .aluCtl (aluCtl)
    );

    RegFile RegFile_inst (
        .clk    (clk),
        .rst    (rst),
        .rAddrA (instr.rs),
        .rAddrB (instr.rt),
        .rDataA (rDataA),
        .rDataB (rDataB),
        .we     (regWe),
        .wAddr  (writeReg),
        .wData  (wbData)
    );

    assign aluB = ctrl.aluSrc ? signExtImm : rDataB;  // Immediate or rt

    Alu Alu_inst (
        .a      (rDataA),
        .b      (aluB),
        .aluCtl (aluCtl),
        .result (aluResult),
        .zero   (zero)
    );

    // Data memory side
    assign dAddr  = aluResult;
    assign dWdata = rDataB;
    assign dWe    = ctrl.memWrite & running;
    assign dRe    = ctrl.memRead & running;

    // Write-back
    assign writeReg = ctrl.regDst ? instr.rd : instr.rt;
    assign wbData   = ctrl.memToReg ? dRdata : aluResult;
    assign regWe    = ctrl.regWrite & running;

    always_comb begin
        retire.en   = regWe && (writeReg != '0);  // Writes to $zero are dropped
        retire.addr = writeReg;
        retire.data = wbData;
    end

endmodule

`default_nettype wire

// File: bench/MipsCore_chk.sv
`timescale 1ns/1ps
`default_nettype none

module MipsCore_chk
    import mipsCtrlPkg::*;
(
    input wire         clk,
    input wire         rst,
    input wire         dWe,
    input wire         dRe,
    input wire retireT retire
);

    memExclusive: assert property (@(posedge clk) !(dWe && dRe))
        else $error("dWe and dRe are high in the same cycle");

    noRetireInReset: assert property (@(posedge clk) rst |-> !retire.en)
        else $error("retire.en is high while rst is high");

    // $zero never shows up in the trace
    noRetireToZero: assert property (@(posedge clk) retire.en |-> (retire.addr != '0))
        else $error("retire.en is high with retire.addr equal to 0");

endmodule

bind MipsCore MipsCore_chk MipsCore_chk_inst (
    .clk    (clk),
    .rst    (rst),
    .dWe    (dWe),
    .dRe    (dRe),
    .retire (retire)
);

`default_nettype wire

// File: bench/MipsCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module MipsCoreTb
    import mipsIsaPkg::*;
    import mipsCtrlPkg::*;
();

    localparam int   ProgLen   = 64;
    localparam int   MemWords  = 64;
    localparam int   RunCycles = 200;
    localparam wordT HaltWord  = 32'h1000ffff;  // beq $0, $0, -1

    logic   clk = 1'b0;
    logic   rst;
    wordT   iAddr;
    instrT  instr;
    wordT   dAddr;
    wordT   dWdata;
    wordT   dRdata;
    logic   dWe;
    logic   dRe;
    retireT retire;

    wordT prog [ProgLen];
    wordT initMem [MemWords];
    wordT dmem [MemWords];
    wordT mPc;                               // Reference model state
    wordT mRegs [NumRegs];
    wordT mMem [MemWords];
    int   errors = 0;
    int   nR = 0;
    int   nLw = 0;
    int   nSw = 0;
    int   nTaken = 0;
    int   nNotTaken = 0;
    int   nUnknown = 0;

    always #50 clk = ~clk;

    MipsCore MipsCore_inst (
        .clk    (clk),
        .rst    (rst),
        .iAddr  (iAddr),
        .instr  (instr),
        .dAddr  (dAddr),
        .dWdata (dWdata),
        .dWe    (dWe),
        .dRe    (dRe),
        .dRdata (dRdata),
        .retire (retire)
    );

    always_comb begin
        if ($isunknown(iAddr)) begin
            instr = '0;                      // Harmless word before the PC is reset
        end else if (iAddr < wordT'(ProgLen * 4)) begin
            instr = prog[iAddr[7:2]];
        end else begin
            instr = HaltWord;                // Spin in place past the end
        end
    end

    assign dRdata = dmem[dAddr[7:2]];

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MemWords; i++) begin
                dmem[i] <= initMem[i];
            end
        end else if (dWe) begin
            dmem[dAddr[7:2]] <= dWdata;
        end
    end

    task automatic checkWord(input string name, input wordT got, input wordT exp);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s got=%b exp=%b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic checkRetire(input retireT got, input retireT exp);
        // Address and data only matter when a write retires
        if ((got.en !== exp.en) || (exp.en && (got !== exp))) begin
            $display("MISMATCH t=%0t retire got=%h exp=%h", $time, got, exp);
            errors++;
        end
    endtask

    function automatic wordT randomInstr();
        instrT ins;
        ins = instrT'($urandom);
        case ($urandom_range(9, 0))
            0, 1, 2, 3: begin
                ins.op    = OpRType;
                ins.shamt = '0;
                case ($urandom_range(4, 0))
                    0:       ins.funct = FnAdd;
                    1:       ins.funct = FnSub;
                    2:       ins.funct = FnAnd;
                    3:       ins.funct = FnOr;
                    default: ins.funct = FnSlt;
                endcase
                if ($urandom_range(7, 0) == 0) begin
                    ins.rd = '0;             // Some writes aim at $zero
                end
            end
            4, 5, 6, 7: begin
                ins.op       = ($urandom_range(1, 0) == 0) ? OpLw : OpSw;
                ins.rs       = '0;           // Absolute word address
                ins[15:0]    = 16'($urandom_range(15, 0) * 4);
            end
            8: begin
                ins.op    = OpBeq;
                ins.rs    = regAddrT'($urandom_range(7, 0));  // Small set makes equal pairs likely
                ins.rt    = regAddrT'($urandom_range(7, 0));
                ins[15:0] = 16'($urandom_range(3, 0));
            end
            default: begin
                while (ins.op inside {OpRType, OpLw, OpSw, OpBeq}) begin
                    ins.op = 6'($urandom);
                end
            end
        endcase
        return wordT'(ins);
    endfunction

    // Compares the current cycle, then advances the model past the next edge
    task automatic stepAndCompare();
        instrT  ins;
        wordT   a;
        wordT   b;
        wordT   imm;
        wordT   addr;
        wordT   res;
        wordT   nextPc;
        retireT expRet;
        logic   expWe;
        logic   expRe;
        logic   inProg;
        inProg = (mPc < wordT'(ProgLen * 4));
        ins    = inProg ? instrT'(prog[mPc[7:2]]) : instrT'(HaltWord);
        a      = mRegs[ins.rs];
        b      = mRegs[ins.rt];
        imm    = {{16{ins[15]}}, ins[15:0]};
        addr   = a + imm;
        nextPc = mPc + 32'd4;
        expRet = '0;
        expWe  = 1'b0;
        expRe  = 1'b0;
        checkWord("iAddr", iAddr, mPc);
        case (ins.op)
            OpRType: begin
                case (ins.funct)
                    FnSub:   res = a - b;
                    FnAnd:   res = a & b;
                    FnOr:    res = a | b;
                    FnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: res = a + b;
                endcase
                expRet.en   = (ins.rd != '0);
                expRet.addr = ins.rd;
                expRet.data = res;
                if (ins.rd != '0) begin
                    mRegs[ins.rd] = res;
                end
                nR++;
            end
            OpLw: begin
                expRe       = 1'b1;
                expRet.en   = (ins.rt != '0);
                expRet.addr = ins.rt;
                expRet.data = mMem[addr[7:2]];
                checkWord("dAddr", dAddr, addr);
                if (ins.rt != '0) begin
                    mRegs[ins.rt] = mMem[addr[7:2]];
                end
                nLw++;
            end
            OpSw: begin
                expWe = 1'b1;
                checkWord("dAddr", dAddr, addr);
                checkWord("dWdata", dWdata, b);
                mMem[addr[7:2]] = b;
                nSw++;
            end
            OpBeq: begin
                if (a == b) begin
                    nextPc = nextPc + (imm << 2);
                end
                if (inProg && (a == b)) begin
                    nTaken++;
                end else if (inProg) begin
                    nNotTaken++;
                end
            end
            default: nUnknown++;             // No side effects expected
        endcase
        checkRetire(retire, expRet);
        checkBit("dWe", dWe, expWe);
        checkBit("dRe", dRe, expRe);
        mPc = nextPc;
    endtask

    initial begin
        int startErr;
        int failedTests;
        failedTests = 0;
        void'($urandom(32'hf26a070b));
        rst = 1'b1;
        for (int i = 0; i < ProgLen; i++) begin
            prog[i] = randomInstr();
        end
        for (int i = 0; i < MemWords; i++) begin
            initMem[i] = $urandom;
            mMem[i]    = initMem[i];
        end
        for (int i = 0; i < NumRegs; i++) begin
            mRegs[i] = '0;
        end
        mPc = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        startErr = errors;                   // Bubble cycle after reset
        checkWord("iAddr", iAddr, '0);
        checkBit("dWe", dWe, 1'b0);
        checkBit("dRe", dRe, 1'b0);
        checkBit("retire.en", retire.en, 1'b0);
        if (errors != startErr) begin
            failedTests++;
        end
        $display("test reset: %s", (errors == startErr) ? "PASS" : "FAIL");

        startErr = errors;
        for (int cyc = 0; cyc < RunCycles; cyc++) begin
            @(negedge clk);
            stepAndCompare();
        end
        if (mPc < wordT'(ProgLen * 4)) begin
            $display("Program did not reach its halt loop within %0d cycles", RunCycles);
            errors++;
        end
        if (errors != startErr) begin
            failedTests++;
        end
        $display("test program: R %0d, lw %0d, sw %0d, taken %0d, not taken %0d, unknown %0d, %s",
                 nR, nLw, nSw, nTaken, nNotTaken, nUnknown,
                 (errors == startErr) ? "PASS" : "FAIL");
        $display("tests 2, failed %0d, errors %0d", failedTests, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #((RunCycles + 20) * 100);
        $display("Timeout: simulation ran past its cycle limit");
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
common/mipsIsaPkg.sv
common/mipsCtrlPkg.sv
src/ControlUnit.sv
alu/AluControl.sv
alu/Alu.sv
src/RegFile.sv
src/MipsCore.sv
bench/MipsCore_chk.sv
bench/MipsCoreTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= MipsCoreTb
FLIST     ?= flist.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

BIN  := $(OBJDIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
